// ==== source/hist_pkg.sv ====
package hist_pkg;

    // apb bus widths
    // paddr is a byte address, bits 1:0 ignored
    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    // field widths of the word address
    // these cap the pixel count at 16 and the bin count at 32
    localparam int max_pixel_w = 4;
    localparam int max_bin_w   = 5;
    localparam int reg_idx_w   = 4;

    // word address seen two ways, picked by the space bit
    // space 0 -> configuration register, space 1 -> frozen bank bin
    typedef union packed {
        struct packed {
            logic                 space;
            logic [4:0]           reserved;
            logic [reg_idx_w-1:0] reg_idx;
        } reg_view;
        struct packed {
            logic                   space;
            logic [max_pixel_w-1:0] pixel;
            logic [max_bin_w-1:0]   bin;
        } bin_view;
    } hist_addr_u;

    // register map
    localparam logic [reg_idx_w-1:0] reg_ctrl           = 4'd0;
    localparam logic [reg_idx_w-1:0] reg_hits_per_pixel = 4'd1;
    localparam logic [reg_idx_w-1:0] reg_acq_num        = 4'd2;
    localparam logic [reg_idx_w-1:0] reg_status         = 4'd3;

    // ctrl bits
    localparam int ctrl_enable_bit     = 0;
    localparam int ctrl_soft_clear_bit = 1;

    // marks a status read inside the otherwise zero register word
    // never set by any configuration value
    localparam int status_sel_bit = 31;

endpackage

// ==== source/hist_apb_regs.sv ====
`timescale 1ns/10ps

module hist_apb_regs import hist_pkg::*; #(
    parameter int num_pixels = 4,
    parameter int num_bins   = 16
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [apb_addr_w-1:0]  paddr,
    input  logic [apb_data_w-1:0]  pwdata,
    output logic                   enable,
    output logic [7:0]             hits_per_pixel,
    output logic [15:0]            acq_num,
    output logic                   soft_clear,
    output logic                   status_clear,
    output logic [max_pixel_w-1:0] rd_pixel,
    output logic [max_bin_w-1:0]   rd_bin,
    output logic                   rd_is_bin,
    output logic [apb_data_w-1:0]  reg_rdata,
    output logic                   err
);

    hist_addr_u            addr_u;
    logic                  setup_phase;
    logic                  access_phase;
    logic                  is_bin;
    logic [reg_idx_w-1:0]  reg_idx;
    logic                  reg_mapped;
    logic                  bin_bad;
    logic                  addr_err;
    logic [apb_data_w-1:0] rdata_next;

    // word address, byte offset dropped
    assign addr_u = paddr[apb_addr_w-1:2];

    assign setup_phase  = psel & ~penable;
    assign access_phase = psel & penable;

    // both views of the same word
    assign is_bin  = addr_u.bin_view.space;
    assign reg_idx = addr_u.reg_view.reg_idx;

    // bin select goes straight to the bank read port
    // the result block samples it at the end of setup
    assign rd_pixel = addr_u.bin_view.pixel;
    assign rd_bin   = addr_u.bin_view.bin;

    assign reg_mapped = reg_idx inside {reg_ctrl, reg_hits_per_pixel, reg_acq_num, reg_status};
    assign bin_bad    = (addr_u.bin_view.pixel >= num_pixels) || (addr_u.bin_view.bin >= num_bins);
    assign addr_err   = is_bin ? bin_bad : ~reg_mapped;

    // register read value
    // status only raises its select bit, the word itself comes later
    always_comb begin
        rdata_next = '0;
        case (reg_idx)
            reg_ctrl: begin
                rdata_next[ctrl_enable_bit] = enable;
            end
            reg_hits_per_pixel: begin
                rdata_next[7:0] = hits_per_pixel;
            end
            reg_acq_num: begin
                rdata_next[15:0] = acq_num;
            end
            reg_status: begin
                rdata_next[status_sel_bit] = 1'b1;
            end
            default: begin
                rdata_next = '0;
            end
        endcase
        // bin reads carry nothing here
        if (is_bin) begin
            rdata_next = '0;
        end
    end

    // read selection and error, latched at the end of setup
    always_ff @(posedge clk or negedge combin_res) begin
        if (~combin_res) begin
            rd_is_bin <= 1'b0;
            err       <= 1'b0;
        end else if (setup_phase) begin
            rd_is_bin <= is_bin;
            err       <= addr_err;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_phase) begin
            reg_rdata <= rdata_next;
        end
    end

    // writes land at the end of the access phase
    // soft clear and status clear are pulses, never stored
    always_ff @(posedge clk or negedge combin_res) begin
        if (~combin_res) begin
            enable         <= 1'b0;
            hits_per_pixel <= 8'd1;
            acq_num        <= 16'd1;
            soft_clear     <= 1'b0;
            status_clear   <= 1'b0;
        end else begin
            soft_clear   <= 1'b0;
            status_clear <= 1'b0;
            if (access_phase && pwrite && !err && !is_bin) begin
                case (reg_idx)
                    reg_ctrl: begin
                        enable     <= pwdata[ctrl_enable_bit];
                        soft_clear <= pwdata[ctrl_soft_clear_bit];
                    end
                    reg_hits_per_pixel: begin
                        // zero would never finish a pixel
                        hits_per_pixel <= (pwdata[7:0] == 8'd0) ? 8'd1 : pwdata[7:0];
                    end
                    reg_acq_num: begin
                        acq_num <= (pwdata[15:0] == 16'd0) ? 16'd1 : pwdata[15:0];
                    end
                    reg_status: begin
                        // write one to clear
                        status_clear <= pwdata[0];
                    end
                    default: begin
                        status_clear <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/hist_bin_accum.sv ====
`timescale 1ns/10ps

module hist_bin_accum import hist_pkg::*; #(
    parameter int num_pixels = 4,
    parameter int num_bins   = 16,
    parameter int count_w    = 16
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   enable,
    input  logic [7:0]             hits_per_pixel,
    input  logic [15:0]            acq_num,
    input  logic                   soft_clear,
    input  logic                   hit_valid,
    input  logic [max_bin_w-1:0]   hit_bin,
    input  logic [max_pixel_w-1:0] rd_pixel,
    input  logic [max_bin_w-1:0]   rd_bin,
    output logic [count_w-1:0]     rd_count,
    output logic                   frame_done,
    output logic                   frozen_bank
);

    // one bank holds every bin of every pixel
    localparam int bank_depth = num_pixels * num_bins;
    localparam int bin_addr_w = $clog2(bank_depth);

    // two banks of counters plus a written flag per counter
    logic [count_w-1:0]    bank_mem [2][bank_depth];
    logic [bank_depth-1:0] written  [2];

    logic                   active_bank;
    logic [7:0]             hit_cnt;
    logic [max_pixel_w-1:0] pixel_cnt;
    logic [15:0]            acq_cnt;

    logic                  hit_acc;
    logic                  bin_ok;
    logic                  last_hit;
    logic                  last_pixel;
    logic                  last_acq;
    logic                  frame_end;
    logic [bin_addr_w-1:0] wr_addr;
    logic                  cur_written;
    logic [count_w-1:0]    cur_count;
    logic [bin_addr_w-1:0] rd_addr;
    logic                  rd_in_range;

    assign frozen_bank = ~active_bank;

    // hits only count while enabled, soft clear wins
    assign hit_acc = enable & hit_valid & ~soft_clear;
    // out of range bins are dropped but still advance the pixel
    assign bin_ok  = hit_bin < num_bins;

    // nested limits, hit inside pixel inside acquisition
    assign last_hit   = hit_cnt >= hits_per_pixel - 8'd1;
    assign last_pixel = pixel_cnt == max_pixel_w'(num_pixels - 1);
    assign last_acq   = acq_cnt >= acq_num - 16'd1;
    assign frame_end  = hit_acc & last_hit & last_pixel & last_acq;

    // counter slot of the incoming hit in the active bank
    assign wr_addr     = bin_addr_w'(pixel_cnt * num_bins) + bin_addr_w'(hit_bin);
    assign cur_written = written[active_bank][wr_addr];
    assign cur_count   = bank_mem[active_bank][wr_addr];

    // pixel, acquisition and bank control
    always_ff @(posedge clk or negedge combin_res) begin
        if (~combin_res) begin
            hit_cnt     <= '0;
            pixel_cnt   <= '0;
            acq_cnt     <= '0;
            active_bank <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (soft_clear) begin
                // restart from the first pixel in bank 0
                hit_cnt     <= '0;
                pixel_cnt   <= '0;
                acq_cnt     <= '0;
                active_bank <= 1'b0;
            end else if (hit_acc) begin
                if (last_hit) begin
                    hit_cnt <= '0;
                    if (last_pixel) begin
                        pixel_cnt <= '0;
                        if (last_acq) begin
                            // frame complete, swap banks
                            acq_cnt     <= '0;
                            active_bank <= ~active_bank;
                        end else begin
                            acq_cnt <= acq_cnt + 16'd1;
                        end
                    end else begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end
                end else begin
                    hit_cnt <= hit_cnt + 8'd1;
                end
            end
        end
    end

    // written flags
    // a fresh bank only loses its flags, the counters stay stale
    always_ff @(posedge clk or negedge combin_res) begin
        if (~combin_res) begin
            written[0] <= '0;
            written[1] <= '0;
        end else if (soft_clear) begin
            written[0] <= '0;
            written[1] <= '0;
        end else begin
            if (hit_acc && bin_ok) begin
                written[active_bank][wr_addr] <= 1'b1;
            end
            // bank about to become active starts empty
            if (frame_end) begin
                written[~active_bank] <= '0;
            end
        end
    end

    // counter storage
    always_ff @(posedge clk) begin
        if (hit_acc && bin_ok) begin
            if (!cur_written) begin
                // first hit, stale content ignored
                bank_mem[active_bank][wr_addr] <= count_w'(1);
            end else if (cur_count != {count_w{1'b1}}) begin
                bank_mem[active_bank][wr_addr] <= cur_count + 1'b1;
            end
        end
    end

    // readout port on the frozen bank
    assign rd_addr     = bin_addr_w'(rd_pixel * num_bins) + bin_addr_w'(rd_bin);
    assign rd_in_range = (rd_pixel < num_pixels) && (rd_bin < num_bins);

    // unwritten or out of range bins read zero
    always_comb begin
        rd_count = '0;
        if (rd_in_range) begin
            if (written[frozen_bank][rd_addr]) begin
                rd_count = bank_mem[frozen_bank][rd_addr];
            end
        end
    end

endmodule

// ==== source/hist_result.sv ====
`timescale 1ns/10ps

module hist_result import hist_pkg::*; #(
    parameter int count_w = 16
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  rd_is_bin,
    input  logic [apb_data_w-1:0] reg_rdata,
    input  logic                  err,
    input  logic [count_w-1:0]    rd_count,
    input  logic                  frame_done,
    input  logic                  frozen_bank,
    input  logic                  status_clear,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pslverr,
    output logic                  irq
);

    logic                  frame_flag;
    logic [15:0]           frame_cnt;
    logic [apb_data_w-1:0] status_word;
    logic [count_w-1:0]    bin_snap;
    logic [apb_data_w-1:0] status_snap;
    logic [apb_data_w-1:0] reg_word;

    // sticky frame flag and wrapping frame counter
    always_ff @(posedge clk or negedge combin_res) begin
        if (~combin_res) begin
            frame_flag <= 1'b0;
            frame_cnt  <= '0;
        end else begin
            if (frame_done) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
            // a new frame beats a clear in the same cycle
            if (frame_done) begin
                frame_flag <= 1'b1;
            end else if (status_clear) begin
                frame_flag <= 1'b0;
            end
        end
    end

    assign irq = frame_flag;

    // status layout
    // bit 0 done, bit 8 frozen bank, 31:16 frame count
    always_comb begin
        status_word        = '0;
        status_word[0]     = frame_flag;
        status_word[8]     = frozen_bank;
        status_word[31:16] = frame_cnt;
    end

    // sampled every edge, so the access phase sees the values
    // from the last setup cycle
    // a read during a bank swap keeps the old frozen bank
    always_ff @(posedge clk) begin
        bin_snap    <= rd_count;
        status_snap <= status_word;
    end

    // register word without its status select bit
    always_comb begin
        reg_word                 = reg_rdata;
        reg_word[status_sel_bit] = 1'b0;
    end

    // read data for the access phase
    always_comb begin
        if (rd_is_bin) begin
            prdata = apb_data_w'(bin_snap);
        end else if (reg_rdata[status_sel_bit]) begin
            prdata = reg_word | status_snap;
        end else begin
            prdata = reg_word;
        end
    end

    // decode error from the setup phase
    assign pslverr = err;

endmodule

// ==== source/hist_top.sv ====
`timescale 1ns/10ps

module hist_top import hist_pkg::*; #(
    parameter int num_pixels = 4,
    parameter int num_bins   = 16,
    parameter int count_w    = 16
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  hit_valid,
    input  logic [max_bin_w-1:0]  hit_bin,
    output logic                  irq
);

    // configuration
    logic                   enable;
    logic [7:0]             hits_per_pixel;
    logic [15:0]            acq_num;
    logic                   soft_clear;
    logic                   status_clear;

    // readout path
    logic [max_pixel_w-1:0] rd_pixel;
    logic [max_bin_w-1:0]   rd_bin;
    logic                   rd_is_bin;
    logic [apb_data_w-1:0]  reg_rdata;
    logic                   err;
    logic [count_w-1:0]     rd_count;

    // frame events
    logic                   frame_done;
    logic                   frozen_bank;

    // zero wait states
    assign pready = 1'b1;

    hist_apb_regs #(
        .num_pixels (num_pixels),
        .num_bins   (num_bins)
    ) i_hist_apb_regs (
        .clk            (clk),
        .combin_res     (combin_res),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .enable         (enable),
        .hits_per_pixel (hits_per_pixel),
        .acq_num        (acq_num),
        .soft_clear     (soft_clear),
        .status_clear   (status_clear),
        .rd_pixel       (rd_pixel),
        .rd_bin         (rd_bin),
        .rd_is_bin      (rd_is_bin),
        .reg_rdata      (reg_rdata),
        .err            (err)
    );

    hist_bin_accum #(
        .num_pixels (num_pixels),
        .num_bins   (num_bins),
        .count_w    (count_w)
    ) i_hist_bin_accum (
        .clk            (clk),
        .combin_res     (combin_res),
        .enable         (enable),
        .hits_per_pixel (hits_per_pixel),
        .acq_num        (acq_num),
        .soft_clear     (soft_clear),
        .hit_valid      (hit_valid),
        .hit_bin        (hit_bin),
        .rd_pixel       (rd_pixel),
        .rd_bin         (rd_bin),
        .rd_count       (rd_count),
        .frame_done     (frame_done),
        .frozen_bank    (frozen_bank)
    );

    hist_result #(
        .count_w (count_w)
    ) i_hist_result (
        .clk          (clk),
        .combin_res   (combin_res),
        .rd_is_bin    (rd_is_bin),
        .reg_rdata    (reg_rdata),
        .err          (err),
        .rd_count     (rd_count),
        .frame_done   (frame_done),
        .frozen_bank  (frozen_bank),
        .status_clear (status_clear),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .irq          (irq)
    );

endmodule

// ==== verification/hist_tb.sv ====
`timescale 1ns/10ps

module hist_tb import hist_pkg::*; ();

    localparam int num_pixels  = 4;
    localparam int num_bins    = 16;
    localparam int count_w     = 4;
    localparam int bank_depth  = num_pixels * num_bins;
    localparam int sat_max     = (1 << count_w) - 1;
    localparam int reset_cycles = 8;
    localparam int max_steps   = 64;

    // step operations
    localparam int op_write = 0;
    localparam int op_read  = 1;
    localparam int op_hits  = 2;
    localparam int op_idle  = 3;

    // expected value taken from the reference model
    localparam logic [31:0] from_model = 32'hFFFF_FFFF;
    // hit burst with random bins
    localparam logic [31:0] any_bin    = 32'hFFFF_FFFF;

    // byte addresses
    localparam logic [11:0] a_ctrl      = 12'h000;
    localparam logic [11:0] a_hpp       = 12'h004;
    localparam logic [11:0] a_acq       = 12'h008;
    localparam logic [11:0] a_status    = 12'h00C;
    localparam logic [11:0] a_unmapped  = 12'h014;
    localparam logic [11:0] a_bins      = 12'h800;
    localparam logic [11:0] a_bad_pixel = 12'hA00;
    localparam logic [11:0] a_bad_bin   = 12'h840;

    logic                  clk;
    logic                  combin_res;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  hit_valid;
    logic [max_bin_w-1:0]  hit_bin;
    logic                  irq;

    // step table
    string       step_name [max_steps];
    int          step_op   [max_steps];
    logic [11:0] step_addr [max_steps];
    logic [31:0] step_data [max_steps];
    int          step_len  [max_steps];
    logic [31:0] step_exp  [max_steps];
    logic        step_err  [max_steps];
    int          n_steps;

    // reference model, two banks of counts
    // an unwritten bin is simply a zero count
    int ref_cnt [2][bank_depth];
    int ref_act;
    int ref_hit;
    int ref_pix;
    int ref_acq;
    int ref_frames;
    int ref_flag;
    int ref_en;
    int ref_hpp;
    int ref_acqn;

    logic [31:0] rnd_state;
    int          cycles;
    int          cycle_limit;

    hist_top #(
        .num_pixels (num_pixels),
        .num_bins   (num_bins),
        .count_w    (count_w)
    ) i_hist_top (
        .clk        (clk),
        .combin_res (combin_res),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .irq        (irq)
    );

    // 40 ns period
    always begin
        #20 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d clock cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_step(input string name, input int op, input logic [11:0] addr,
                            input logic [31:0] data, input int len,
                            input logic [31:0] exp, input logic exp_err);
        step_name[n_steps] = name;
        step_op[n_steps]   = op;
        step_addr[n_steps] = addr;
        step_data[n_steps] = data;
        step_len[n_steps]  = len;
        step_exp[n_steps]  = exp;
        step_err[n_steps]  = exp_err;
        n_steps++;
    endtask

    task automatic clear_bank(input int bank);
        for (int i = 0; i < bank_depth; i++) begin
            ref_cnt[bank][i] = 0;
        end
    endtask

    // one accepted hit, counter chain hit -> pixel -> acquisition
    task automatic model_hit(input int bin);
        int idx;
        if (ref_en != 0) begin
            // out of range bins only advance the chain
            if (bin < num_bins) begin
                idx = ref_pix * num_bins + bin;
                if (ref_cnt[ref_act][idx] < sat_max) begin
                    ref_cnt[ref_act][idx]++;
                end
            end
            if (ref_hit >= ref_hpp - 1) begin
                ref_hit = 0;
                if (ref_pix == num_pixels - 1) begin
                    ref_pix = 0;
                    if (ref_acq >= ref_acqn - 1) begin
                        // frame end, new active bank starts empty
                        ref_acq = 0;
                        clear_bank(1 - ref_act);
                        ref_act = 1 - ref_act;
                        ref_frames++;
                        ref_flag = 1;
                    end else begin
                        ref_acq++;
                    end
                end else begin
                    ref_pix++;
                end
            end else begin
                ref_hit++;
            end
        end
    endtask

    // register write seen by the model, bin space ignored
    task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
        if (!addr[11]) begin
            case (addr[5:2])
                4'd0: begin
                    ref_en = data[0];
                    if (data[1]) begin
                        clear_bank(0);
                        clear_bank(1);
                        ref_hit = 0;
                        ref_pix = 0;
                        ref_acq = 0;
                        ref_act = 0;
                    end
                end
                4'd1: begin
                    ref_hpp = (data[7:0] == 8'd0) ? 1 : int'(data[7:0]);
                end
                4'd2: begin
                    ref_acqn = (data[15:0] == 16'd0) ? 1 : int'(data[15:0]);
                end
                4'd3: begin
                    if (data[0]) begin
                        ref_flag = 0;
                    end
                end
                default: begin
                    ref_flag = ref_flag;
                end
            endcase
        end
    endtask

    // done in bit 0, frozen bank in bit 8, frame count on top
    function automatic logic [31:0] expected_status();
        logic [31:0] w;
        w        = '0;
        w[0]     = ref_flag[0];
        w[8]     = ~ref_act[0];
        w[31:16] = ref_frames[15:0];
        return w;
    endfunction

    function automatic logic [11:0] bin_address(input int idx);
        logic [11:0] a;
        a        = a_bins;
        a[10:7]  = 4'((idx / num_bins));
        a[6:2]   = 5'((idx % num_bins));
        return a;
    endfunction

    // setup and access phase, data sampled mid access phase
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata  = prdata;
        slverr = pslverr;
    endtask

    task automatic release_bus();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic send_hits(input int n, input logic [31:0] sel);
        int bin;
        for (int i = 0; i < n; i++) begin
            if (sel == any_bin) begin
                bin = int'(xorshift() % 32);
            end else begin
                bin = int'(sel[4:0]);
            end
            @(posedge clk);
            hit_valid <= 1'b1;
            hit_bin   <= bin[4:0];
            model_hit(bin);
        end
        @(posedge clk);
        hit_valid <= 1'b0;
        hit_bin   <= '0;
    endtask

    task automatic run_step(input int i);
        logic [31:0] rdata;
        logic [31:0] expv;
        logic        slverr;
        logic [11:0] a;
        int          start;
        string       name;
        start = int'(step_addr[i][10:7]) * num_bins + int'(step_addr[i][6:2]);
        case (step_op[i])
            op_write: begin
                apb_transfer(1'b1, step_addr[i], step_data[i], rdata, slverr);
                compare_values({step_name[i], " pslverr"}, 32'(step_err[i]), 32'(slverr));
                if (!step_err[i]) begin
                    model_write(step_addr[i], step_data[i]);
                end
                release_bus();
            end
            op_read: begin
                for (int k = 0; k < step_len[i]; k++) begin
                    name = $sformatf("%s[%0d]", step_name[i], k);
                    a    = step_addr[i];
                    // a model-checked bin read walks the frozen bank
                    if (a[11] && step_exp[i] == from_model) begin
                        a = bin_address(start + k);
                    end
                    apb_transfer(1'b0, a, '0, rdata, slverr);
                    compare_values({name, " pready"}, 32'd1, 32'(pready));
                    compare_values({name, " pslverr"}, 32'(step_err[i]), 32'(slverr));
                    if (!step_err[i]) begin
                        expv = step_exp[i];
                        if (step_exp[i] == from_model && a[11]) begin
                            expv = ref_cnt[1 - ref_act][start + k];
                        end else if (step_exp[i] == from_model) begin
                            expv = expected_status();
                            compare_values({name, " irq"}, 32'(ref_flag), 32'(irq));
                        end
                        compare_values(name, expv, rdata);
                    end
                end
                release_bus();
            end
            op_hits: begin
                send_hits(step_len[i], step_data[i]);
            end
            default: begin
                repeat (step_len[i]) @(posedge clk);
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        combin_res = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        hit_valid  = 1'b0;
        hit_bin    = '0;
        rnd_state  = 32'd83;
        cycles     = 0;
        n_steps    = 0;
        clear_bank(0);
        clear_bank(1);
        ref_act    = 0;
        ref_hit    = 0;
        ref_pix    = 0;
        ref_acq    = 0;
        ref_frames = 0;
        ref_flag   = 0;
        ref_en     = 0;
        ref_hpp    = 1;
        ref_acqn   = 1;

        // register access and decode errors
        add_step("reset ctrl", op_read, a_ctrl, 0, 1, 0, 0);
        add_step("reset hits_per_pixel", op_read, a_hpp, 0, 1, 1, 0);
        add_step("reset acq_num", op_read, a_acq, 0, 1, 1, 0);
        add_step("reset status", op_read, a_status, 0, 1, from_model, 0);
        add_step("hpp zero", op_write, a_hpp, 0, 1, 0, 0);
        add_step("hpp zero readback", op_read, a_hpp, 0, 1, 1, 0);
        add_step("acq zero", op_write, a_acq, 0, 1, 0, 0);
        add_step("acq zero readback", op_read, a_acq, 0, 1, 1, 0);
        add_step("hpp write", op_write, a_hpp, 3, 1, 0, 0);
        add_step("acq write", op_write, a_acq, 2, 1, 0, 0);
        add_step("unmapped write", op_write, a_unmapped, 32'hFF, 1, 0, 1);
        add_step("unmapped read", op_read, a_unmapped, 0, 1, 0, 1);
        add_step("bad pixel read", op_read, a_bad_pixel, 0, 1, 0, 1);
        add_step("bad bin read", op_read, a_bad_bin, 0, 1, 0, 1);
        add_step("bad bin write", op_write, a_bad_bin, 5, 1, 0, 1);
        // the bad bin word decodes to the ctrl index in the register view
        add_step("ctrl unchanged", op_read, a_ctrl, 0, 1, 0, 0);
        add_step("hpp readback", op_read, a_hpp, 0, 1, 3, 0);
        add_step("acq readback", op_read, a_acq, 0, 1, 2, 0);
        add_step("enable", op_write, a_ctrl, 1, 1, 0, 0);
        add_step("ctrl readback", op_read, a_ctrl, 0, 1, 1, 0);
        // one full frame, 3 hits x 4 pixels x 2 acquisitions
        add_step("frame 1 hits", op_hits, 0, any_bin, 24, 0, 0);
        add_step("frame 1 settle", op_idle, 0, 0, 2, 0, 0);
        add_step("frame 1 status", op_read, a_status, 0, 1, from_model, 0);
        add_step("frame 1 bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        // second frame must not disturb the frozen bank
        add_step("frame 2 partial", op_hits, 0, any_bin, 10, 0, 0);
        add_step("frozen unchanged", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("frame 2 rest", op_hits, 0, any_bin, 14, 0, 0);
        add_step("frame 2 settle", op_idle, 0, 0, 2, 0, 0);
        add_step("frame 2 bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("frame 2 status", op_read, a_status, 0, 1, from_model, 0);
        add_step("irq hold", op_idle, 0, 0, 4, 0, 0);
        add_step("irq hold status", op_read, a_status, 0, 1, from_model, 0);
        add_step("status clear", op_write, a_status, 1, 1, 0, 0);
        add_step("cleared status", op_read, a_status, 0, 1, from_model, 0);
        // 20 hits into one bin per pixel, 4 bit counters
        add_step("sat hpp", op_write, a_hpp, 20, 1, 0, 0);
        add_step("sat acq", op_write, a_acq, 1, 1, 0, 0);
        add_step("sat hits", op_hits, 0, 5, 80, 0, 0);
        add_step("sat settle", op_idle, 0, 0, 2, 0, 0);
        add_step("sat bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("sat status", op_read, a_status, 0, 1, from_model, 0);
        // enable off, then soft clear
        // a full frame of hits, so a missed enable would swap the banks
        add_step("disable", op_write, a_ctrl, 0, 1, 0, 0);
        add_step("disabled hits", op_hits, 0, any_bin, 80, 0, 0);
        add_step("disabled bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("disabled status", op_read, a_status, 0, 1, from_model, 0);
        add_step("reenable", op_write, a_ctrl, 1, 1, 0, 0);
        add_step("pre clear hits", op_hits, 0, any_bin, 7, 0, 0);
        add_step("soft clear", op_write, a_ctrl, 3, 1, 0, 0);
        add_step("ctrl after clear", op_read, a_ctrl, 0, 1, 1, 0);
        add_step("cleared bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("restart hits", op_hits, 0, any_bin, 80, 0, 0);
        add_step("restart settle", op_idle, 0, 0, 2, 0, 0);
        add_step("restart bins", op_read, a_bins, 0, bank_depth, from_model, 0);
        add_step("restart status", op_read, a_status, 0, 1, from_model, 0);

        // burst lengths plus two per bus step, doubled
        cycle_limit = 0;
        for (int i = 0; i < n_steps; i++) begin
            cycle_limit += step_len[i];
            if (step_op[i] == op_write || step_op[i] == op_read) begin
                cycle_limit += 2;
            end
        end
        cycle_limit = 2 * cycle_limit + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        combin_res <= 1'b1;

        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
source/hist_pkg.sv
source/hist_apb_regs.sv
source/hist_bin_accum.sv
source/hist_result.sv
source/hist_top.sv
verification/hist_tb.sv

// ==== Bender.yml ====
package:
  name: hist

sources:
  - files:
      - source/hist_pkg.sv
      - source/hist_apb_regs.sv
      - source/hist_bin_accum.sv
      - source/hist_result.sv
      - source/hist_top.sv
  - target: test
    files:
      - verification/hist_tb.sv
